// ==== mempool_group.f ====
+incdir+.
tcdm_pkg.sv
tcdm_req_xbar.sv
tcdm_spill_reg.sv
tcdm_bank.sv
tcdm_resp_xbar.sv
mempool_group.sv
tb_mempool_group.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= mempool_group.f
TB_TOP    ?= tb_mempool_group
RTL_TOP   ?= mempool_group
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps -Wno-fatal
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_mempool_group.sv ====
// MemPool group testbench
// Drives the four tile ports, keeps a reference memory and checks read
// data, fairness, latency and response hold under back-pressure

`timescale 1ns/1ps
`default_nettype none

`include "mempool_settings.svh"

module tb_mempool_group;

  import tcdm_pkg::*;

  localparam int num_tiles  = `MEMPOOL_NUM_TILES;
  localparam int num_words  = 2 ** `MEMPOOL_ADDR_WIDTH;
  localparam int num_random = 50;
  // Preload, directed tests and random streams
  localparam int num_txns   = num_words + 2 + num_tiles + 3 * num_tiles + 1 +
                              num_tiles * num_random;
  localparam int max_cycles = num_txns * 20 + 100;

  logic                                          clk;
  logic                                          rst_n;
  logic [num_tiles-1:0]                          req_valid;
  logic [num_tiles-1:0]                          req_ready;
  tcdm_addr_u [num_tiles-1:0]                    req_addr;
  logic [num_tiles-1:0]                          req_wen;
  logic [num_tiles-1:0][`MEMPOOL_DATA_WIDTH-1:0] req_wdata;
  logic [num_tiles-1:0][`MEMPOOL_BE_WIDTH-1:0]   req_be;
  logic [num_tiles-1:0]                          resp_valid;
  logic [num_tiles-1:0]                          resp_ready;
  logic [num_tiles-1:0][`MEMPOOL_DATA_WIDTH-1:0] resp_rdata;

  logic [`MEMPOOL_DATA_WIDTH-1:0] ref_mem [num_words];
  logic [`MEMPOOL_DATA_WIDTH-1:0] exp_rdata [num_tiles];
  logic                           exp_read [num_tiles];
  int                             outstanding [num_tiles];
  int                             accept_cycle [num_tiles];
  int                             issue_mark [num_tiles];
  int                             bank_xfers [`MEMPOOL_NUM_BANKS];
  int                             cycle;
  int                             accepts;
  int                             resps;
  int                             data_errors;
  int                             protocol_errors;
  int                             hold_errors;
  integer                         seed;

  logic [`MEMPOOL_ADDR_WIDTH-1:0] rnd_addr [num_tiles][num_random];
  logic                           rnd_wen [num_tiles][num_random];
  logic [`MEMPOOL_DATA_WIDTH-1:0] rnd_wdata [num_tiles][num_random];
  logic [`MEMPOOL_BE_WIDTH-1:0]   rnd_be [num_tiles][num_random];

  mempool_group u_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_addr_i   (req_addr),
    .req_wen_i    (req_wen),
    .req_wdata_i  (req_wdata),
    .req_be_i     (req_be),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .resp_rdata_o (resp_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Preload pattern, every address bit shows up in the word
  function automatic logic [31:0] fill_word(input logic [7:0] addr);
    return {addr, ~addr, addr ^ 8'h3c, addr + 8'h71};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    for (int i = 0; i < 4; i++) begin
      mask[i*8 +: 8] = {8{be[i]}};
    end
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // Entered 1 ns after a rising edge, left 1 ns after the response edge
  task automatic transact(input int t, input logic [7:0] addr, input logic wen,
                          input logic [31:0] wdata, input logic [3:0] be);
    tcdm_addr_u a;
    a.raw         = addr;
    issue_mark[t] = bank_xfers[a.fields.bank];
    req_valid[t]  = 1'b1;
    req_addr[t]   = a;
    req_wen[t]    = wen;
    req_wdata[t]  = wdata;
    req_be[t]     = be;
    do @(negedge clk); while (!req_ready[t]);
    @(posedge clk);
    #1;
    req_valid[t] = 1'b0;
    do @(negedge clk); while (!(resp_valid[t] && resp_ready[t]));
    @(posedge clk);
    #1;
  endtask

  task automatic preload_tile(input int t);
    logic [7:0] addr;
    for (int i = 0; i < num_words / num_tiles; i++) begin
      addr = 8'(t * (num_words / num_tiles) + i);
      transact(t, addr, 1'b1, fill_word(addr), 4'hf);
    end
  endtask

  // Three reads per tile, all landing in bank 1
  task automatic same_bank_reads(input int t);
    for (int k = 0; k < 3; k++) begin
      transact(t, 8'((t * 3 + k) * 4 + 1), 1'b0, '0, '0);
    end
  endtask

  task automatic random_stream(input int t);
    for (int i = 0; i < num_random; i++) begin
      transact(t, rnd_addr[t][i], rnd_wen[t][i], rnd_wdata[t][i], rnd_be[t][i]);
    end
  endtask

  task automatic make_random_tables();
    logic [31:0] rnd;
    for (int t = 0; t < num_tiles; t++) begin
      for (int i = 0; i < num_random; i++) begin
        rnd = $random(seed);
        rnd_addr[t][i] = rnd[7:0];
        rnd_wen[t][i]  = rnd[8];
        rnd_be[t][i]   = rnd[12:9];
        rnd_wdata[t][i] = $random(seed);
      end
    end
  endtask

  // Handshakes are settled at the falling edge and complete on the next rise
  always @(negedge clk) begin : monitor
    tcdm_addr_u a;
    cycle = cycle + 1;
    if (rst_n) begin
      for (int t = 0; t < num_tiles; t++) begin
        if (resp_valid[t]) begin
          assert (outstanding[t] > 0) else begin
            protocol_errors++;
            $display("tile %0d got a response at %0t with no request outstanding", t, $time);
          end
        end
        if (resp_valid[t] && resp_ready[t]) begin
          resps++;
        end
        if (resp_valid[t] && resp_ready[t] && outstanding[t] > 0) begin
          assert (cycle - accept_cycle[t] >= 2) else begin
            protocol_errors++;
            $display("tile %0d response at %0t came less than 2 cycles after accept",
                     t, $time);
          end
          if (exp_read[t]) begin
            assert (resp_rdata[t] === exp_rdata[t]) else begin
              data_errors++;
              $display("error at %0t: resp_rdata_o[%0d] expected %h actual %h",
                       $time, t, exp_rdata[t], resp_rdata[t]);
            end
          end
          outstanding[t]--;
        end
        if (req_valid[t] && req_ready[t]) begin
          a = req_addr[t];
          assert (bank_xfers[a.fields.bank] - issue_mark[t] < num_tiles) else begin
            protocol_errors++;
            $display("tile %0d waited more than %0d transfers on bank %0d at %0t",
                     t, num_tiles, a.fields.bank, $time);
          end
          bank_xfers[a.fields.bank]++;
          exp_read[t]  = !req_wen[t];
          exp_rdata[t] = ref_mem[a.raw];
          if (req_wen[t]) begin
            ref_mem[a.raw] = merge_bytes(ref_mem[a.raw], req_wdata[t], req_be[t]);
          end
          accept_cycle[t] = cycle;
          outstanding[t]++;
          accepts++;
        end
      end
    end
  end

  // Held response stays put while the tile is not ready
  for (genvar g = 0; g < num_tiles; g++) begin : gen_hold_checks
    assert property (@(posedge clk) disable iff (!rst_n)
      (resp_valid[g] && !resp_ready[g]) |=> (resp_valid[g] && $stable(resp_rdata[g])))
    else begin
      hold_errors++;
      $display("tile %0d response changed at %0t while resp_ready_i was low", g, $time);
    end
  end

  initial begin
    seed            = 32'h65285154;
    rst_n           = 1'b0;
    req_valid       = '0;
    req_addr        = '0;
    req_wen         = '0;
    req_wdata       = '0;
    req_be          = '0;
    resp_ready      = '1;
    cycle           = 0;
    accepts         = 0;
    resps           = 0;
    data_errors     = 0;
    protocol_errors = 0;
    hold_errors     = 0;
    for (int t = 0; t < num_tiles; t++) begin
      outstanding[t]  = 0;
      accept_cycle[t] = 0;
      issue_mark[t]   = 0;
      exp_read[t]     = 1'b0;
      exp_rdata[t]    = '0;
      bank_xfers[t]   = 0;
    end
    make_random_tables();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    assert (resp_valid === '0) else begin
      protocol_errors++;
      $display("error at %0t: resp_valid_o expected %b actual %b",
               $time, {num_tiles{1'b0}}, resp_valid);
    end
    @(posedge clk);
    #1;

    fork
      preload_tile(0);
      preload_tile(1);
      preload_tile(2);
      preload_tile(3);
    join

    // Partial write, then read back from another tile
    transact(0, 8'h25, 1'b1, 32'hdead_beef, 4'b0101);
    transact(2, 8'h25, 1'b0, '0, '0);

    // One bank each, all taken in the same cycle
    fork
      transact(0, 8'h43, 1'b0, '0, '0);
      transact(1, 8'h86, 1'b0, '0, '0);
      transact(2, 8'hc9, 1'b0, '0, '0);
      transact(3, 8'h0c, 1'b0, '0, '0);
      begin
        @(negedge clk);
        assert (req_ready === '1) else begin
          protocol_errors++;
          $display("error at %0t: req_ready_o expected %b actual %b",
                   $time, {num_tiles{1'b1}}, req_ready);
        end
      end
    join

    fork
      same_bank_reads(0);
      same_bank_reads(1);
      same_bank_reads(2);
      same_bank_reads(3);
    join

    // Tile 3 holds off its response for a few cycles
    resp_ready[3] = 1'b0;
    fork
      transact(3, 8'h7e, 1'b0, '0, '0);
      begin
        do @(negedge clk); while (!resp_valid[3]);
        repeat (5) @(posedge clk);
        #1;
        resp_ready[3] = 1'b1;
      end
    join

    fork
      random_stream(0);
      random_stream(1);
      random_stream(2);
      random_stream(3);
    join

    repeat (4) @(posedge clk);
    assert (accepts == resps) else begin
      protocol_errors++;
      $display("%0d requests accepted but %0d responses seen", accepts, resps);
    end

    $display("errors: data %0d, protocol %0d, hold %0d",
             data_errors, protocol_errors, hold_errors);
    if (data_errors + protocol_errors + hold_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    repeat (max_cycles) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", max_cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mempool_group.sv ====
// MemPool group, local TCDM path
// Request crossbar, per-bank spill register and bank, and the
// response crossbar back to the tiles

`timescale 1ns/1ps
`default_nettype none

`include "mempool_settings.svh"

module mempool_group (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic [`MEMPOOL_NUM_TILES-1:0]                          req_valid_i,
  output logic [`MEMPOOL_NUM_TILES-1:0]                          req_ready_o,
  input  tcdm_pkg::tcdm_addr_u [`MEMPOOL_NUM_TILES-1:0]          req_addr_i,
  input  logic [`MEMPOOL_NUM_TILES-1:0]                          req_wen_i,
  input  logic [`MEMPOOL_NUM_TILES-1:0][`MEMPOOL_DATA_WIDTH-1:0] req_wdata_i,
  input  logic [`MEMPOOL_NUM_TILES-1:0][`MEMPOOL_BE_WIDTH-1:0]   req_be_i,
  output logic [`MEMPOOL_NUM_TILES-1:0]                          resp_valid_o,
  input  logic [`MEMPOOL_NUM_TILES-1:0]                          resp_ready_i,
  output logic [`MEMPOOL_NUM_TILES-1:0][`MEMPOOL_DATA_WIDTH-1:0] resp_rdata_o
);

  // Crossbar to spill register
  logic [`MEMPOOL_NUM_BANKS-1:0]                               xbar_valid;
  logic [`MEMPOOL_NUM_BANKS-1:0]                               xbar_ready;
  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_ROW_WIDTH-1:0]       xbar_row;
  logic [`MEMPOOL_NUM_BANKS-1:0]                               xbar_wen;
  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_DATA_WIDTH-1:0]      xbar_wdata;
  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_BE_WIDTH-1:0]        xbar_be;
  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_TILE_IDX_WIDTH-1:0]  xbar_ini;
  // Spill register to bank
  logic [`MEMPOOL_NUM_BANKS-1:0]                               spill_valid;
  logic [`MEMPOOL_NUM_BANKS-1:0]                               spill_ready;
  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_ROW_WIDTH-1:0]       spill_row;
  logic [`MEMPOOL_NUM_BANKS-1:0]                               spill_wen;
  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_DATA_WIDTH-1:0]      spill_wdata;
  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_BE_WIDTH-1:0]        spill_be;
  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_TILE_IDX_WIDTH-1:0]  spill_ini;
  // Bank responses
  logic [`MEMPOOL_NUM_BANKS-1:0]                               bank_resp_valid;
  logic [`MEMPOOL_NUM_BANKS-1:0]                               bank_resp_ready;
  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_DATA_WIDTH-1:0]      bank_resp_rdata;
  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_TILE_IDX_WIDTH-1:0]  bank_resp_ini;

  tcdm_req_xbar u_req_xbar (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_addr_i   (req_addr_i),
    .req_wen_i    (req_wen_i),
    .req_wdata_i  (req_wdata_i),
    .req_be_i     (req_be_i),
    .bank_valid_o (xbar_valid),
    .bank_ready_i (xbar_ready),
    .bank_row_o   (xbar_row),
    .bank_wen_o   (xbar_wen),
    .bank_wdata_o (xbar_wdata),
    .bank_be_o    (xbar_be),
    .bank_ini_o   (xbar_ini)
  );

  for (genvar b = 0; b < `MEMPOOL_NUM_BANKS; b++) begin : gen_banks
    tcdm_spill_reg u_spill (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (xbar_valid[b]),
      .ready_o (xbar_ready[b]),
      .row_i   (xbar_row[b]),
      .wen_i   (xbar_wen[b]),
      .wdata_i (xbar_wdata[b]),
      .be_i    (xbar_be[b]),
      .ini_i   (xbar_ini[b]),
      .valid_o (spill_valid[b]),
      .ready_i (spill_ready[b]),
      .row_o   (spill_row[b]),
      .wen_o   (spill_wen[b]),
      .wdata_o (spill_wdata[b]),
      .be_o    (spill_be[b]),
      .ini_o   (spill_ini[b])
    );

    tcdm_bank u_bank (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_valid_i  (spill_valid[b]),
      .req_ready_o  (spill_ready[b]),
      .req_row_i    (spill_row[b]),
      .req_wen_i    (spill_wen[b]),
      .req_wdata_i  (spill_wdata[b]),
      .req_be_i     (spill_be[b]),
      .req_ini_i    (spill_ini[b]),
      .resp_valid_o (bank_resp_valid[b]),
      .resp_ready_i (bank_resp_ready[b]),
      .resp_rdata_o (bank_resp_rdata[b]),
      .resp_ini_o   (bank_resp_ini[b])
    );
  end

  tcdm_resp_xbar u_resp_xbar (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bank_valid_i (bank_resp_valid),
    .bank_ready_o (bank_resp_ready),
    .bank_rdata_i (bank_resp_rdata),
    .bank_ini_i   (bank_resp_ini),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o)
  );

endmodule

`default_nettype wire

// ==== tcdm_resp_xbar.sv ====
// TCDM response crossbar
// Steers each bank response back to the tile named by its tag,
// round-robin among banks that target the same tile

`timescale 1ns/1ps
`default_nettype none

`include "mempool_settings.svh"

module tcdm_resp_xbar (
  input  logic                                                       clk_i,
  input  logic                                                       rst_n_i,
  // Bank side
  input  logic [`MEMPOOL_NUM_BANKS-1:0]                              bank_valid_i,
  output logic [`MEMPOOL_NUM_BANKS-1:0]                              bank_ready_o,
  input  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_DATA_WIDTH-1:0]     bank_rdata_i,
  input  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_TILE_IDX_WIDTH-1:0] bank_ini_i,
  // Tile side
  output logic [`MEMPOOL_NUM_TILES-1:0]                              resp_valid_o,
  input  logic [`MEMPOOL_NUM_TILES-1:0]                              resp_ready_i,
  output logic [`MEMPOOL_NUM_TILES-1:0][`MEMPOOL_DATA_WIDTH-1:0]     resp_rdata_o
);

  import tcdm_pkg::*;

  logic [`MEMPOOL_NUM_TILES-1:0][`MEMPOOL_NUM_BANKS-1:0]      tile_req;
  logic [`MEMPOOL_NUM_TILES-1:0][`MEMPOOL_BANK_IDX_WIDTH-1:0] winner;
  logic [`MEMPOOL_NUM_TILES-1:0][`MEMPOOL_BANK_IDX_WIDTH-1:0] rr_ptr;

  always_comb begin
    bank_ready_o = '0;
    for (int t = 0; t < `MEMPOOL_NUM_TILES; t++) begin
      for (int b = 0; b < `MEMPOOL_NUM_BANKS; b++) begin
        tile_req[t][b] = bank_valid_i[b] &&
                         (bank_ini_i[b] == t[`MEMPOOL_TILE_IDX_WIDTH-1:0]);
      end
      winner[t]       = rr_pick(tile_req[t], rr_ptr[t]);
      resp_valid_o[t] = |tile_req[t];
      resp_rdata_o[t] = bank_rdata_i[winner[t]];
      // Losing banks keep their response held
      if (resp_valid_o[t] && resp_ready_i[t]) begin
        bank_ready_o[winner[t]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr <= '0;
    end else begin
      for (int t = 0; t < `MEMPOOL_NUM_TILES; t++) begin
        if (resp_valid_o[t] && resp_ready_i[t]) begin
          rr_ptr[t] <= winner[t] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tcdm_bank.sv ====
// TCDM bank
// Single-port word memory with byte-enable writes and a response
// register that holds until taken

`timescale 1ns/1ps
`default_nettype none

`include "mempool_settings.svh"

module tcdm_bank (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  input  logic [`MEMPOOL_ROW_WIDTH-1:0]      req_row_i,
  input  logic                               req_wen_i,
  input  logic [`MEMPOOL_DATA_WIDTH-1:0]     req_wdata_i,
  input  logic [`MEMPOOL_BE_WIDTH-1:0]       req_be_i,
  input  logic [`MEMPOOL_TILE_IDX_WIDTH-1:0] req_ini_i,
  output logic                               resp_valid_o,
  input  logic                               resp_ready_i,
  output logic [`MEMPOOL_DATA_WIDTH-1:0]     resp_rdata_o,
  output logic [`MEMPOOL_TILE_IDX_WIDTH-1:0] resp_ini_o
);

  import tcdm_pkg::*;

  localparam int unsigned num_words = 2 ** `MEMPOOL_ROW_WIDTH;

  logic [`MEMPOOL_DATA_WIDTH-1:0] mem [num_words];
  logic                           accept;

  // Free slot, or the held response leaves this cycle
  assign req_ready_o = !resp_valid_o || resp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= 1'b0;
    end else if (accept) begin
      resp_valid_o <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_o <= 1'b0;
    end
  end

  // Read returns the word as it was before this request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_rdata_o <= mem[req_row_i];
      resp_ini_o   <= req_ini_i;
      if (req_wen_i) begin
        mem[req_row_i] <= be_merge(mem[req_row_i], req_wdata_i, req_be_i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tcdm_spill_reg.sv ====
// TCDM request spill register
// Two-entry buffer in front of a bank, full throughput with a
// ready that depends only on the fill level

`timescale 1ns/1ps
`default_nettype none

`include "mempool_settings.svh"

module tcdm_spill_reg (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               valid_i,
  output logic                               ready_o,
  input  logic [`MEMPOOL_ROW_WIDTH-1:0]      row_i,
  input  logic                               wen_i,
  input  logic [`MEMPOOL_DATA_WIDTH-1:0]     wdata_i,
  input  logic [`MEMPOOL_BE_WIDTH-1:0]       be_i,
  input  logic [`MEMPOOL_TILE_IDX_WIDTH-1:0] ini_i,
  output logic                               valid_o,
  input  logic                               ready_i,
  output logic [`MEMPOOL_ROW_WIDTH-1:0]      row_o,
  output logic                               wen_o,
  output logic [`MEMPOOL_DATA_WIDTH-1:0]     wdata_o,
  output logic [`MEMPOOL_BE_WIDTH-1:0]       be_o,
  output logic [`MEMPOOL_TILE_IDX_WIDTH-1:0] ini_o
);

  localparam int unsigned payload_width = `MEMPOOL_ROW_WIDTH + 1 + `MEMPOOL_DATA_WIDTH +
                                          `MEMPOOL_BE_WIDTH + `MEMPOOL_TILE_IDX_WIDTH;

  logic [payload_width-1:0] main_q;
  logic [payload_width-1:0] spill_q;
  logic                     main_full;
  logic                     spill_full;
  logic                     main_fill;
  logic                     main_drain;
  logic                     spill_fill;
  logic                     spill_drain;

  assign ready_o     = !main_full || !spill_full;
  assign main_fill   = valid_i && ready_o;
  assign main_drain  = main_full && !spill_full;
  // Main entry parks in the spill slot when the bank stalls
  assign spill_fill  = main_drain && !ready_i;
  assign spill_drain = spill_full && ready_i;

  assign valid_o = main_full || spill_full;
  assign {row_o, wen_o, wdata_o, be_o, ini_o} = spill_full ? spill_q : main_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      main_full  <= 1'b0;
      spill_full <= 1'b0;
    end else begin
      if (main_fill) begin
        main_full <= 1'b1;
      end else if (main_drain) begin
        main_full <= 1'b0;
      end
      if (spill_fill) begin
        spill_full <= 1'b1;
      end else if (spill_drain) begin
        spill_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_fill) begin
      main_q <= {row_i, wen_i, wdata_i, be_i, ini_i};
    end
    if (spill_fill) begin
      spill_q <= main_q;
    end
  end

endmodule

`default_nettype wire

// ==== tcdm_req_xbar.sv ====
// TCDM request crossbar
// Decodes the bank field of each tile request, arbitrates round-robin
// per bank and tags the forwarded request with the winning tile index

`timescale 1ns/1ps
`default_nettype none

`include "mempool_settings.svh"

module tcdm_req_xbar (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  // Tile side
  input  logic [`MEMPOOL_NUM_TILES-1:0]                            req_valid_i,
  output logic [`MEMPOOL_NUM_TILES-1:0]                            req_ready_o,
  input  tcdm_pkg::tcdm_addr_u [`MEMPOOL_NUM_TILES-1:0]            req_addr_i,
  input  logic [`MEMPOOL_NUM_TILES-1:0]                            req_wen_i,
  input  logic [`MEMPOOL_NUM_TILES-1:0][`MEMPOOL_DATA_WIDTH-1:0]   req_wdata_i,
  input  logic [`MEMPOOL_NUM_TILES-1:0][`MEMPOOL_BE_WIDTH-1:0]     req_be_i,
  // Bank side
  output logic [`MEMPOOL_NUM_BANKS-1:0]                            bank_valid_o,
  input  logic [`MEMPOOL_NUM_BANKS-1:0]                            bank_ready_i,
  output logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_ROW_WIDTH-1:0]    bank_row_o,
  output logic [`MEMPOOL_NUM_BANKS-1:0]                            bank_wen_o,
  output logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_DATA_WIDTH-1:0]   bank_wdata_o,
  output logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_BE_WIDTH-1:0]     bank_be_o,
  output logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_TILE_IDX_WIDTH-1:0] bank_ini_o
);

  import tcdm_pkg::*;

  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_NUM_TILES-1:0]      bank_req;
  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_TILE_IDX_WIDTH-1:0] winner;
  logic [`MEMPOOL_NUM_BANKS-1:0][`MEMPOOL_TILE_IDX_WIDTH-1:0] rr_ptr;

  always_comb begin
    req_ready_o = '0;
    for (int b = 0; b < `MEMPOOL_NUM_BANKS; b++) begin
      for (int t = 0; t < `MEMPOOL_NUM_TILES; t++) begin
        bank_req[b][t] = req_valid_i[t] &&
                         (req_addr_i[t].fields.bank == b[`MEMPOOL_BANK_IDX_WIDTH-1:0]);
      end
      winner[b]       = rr_pick(bank_req[b], rr_ptr[b]);
      bank_valid_o[b] = |bank_req[b];
      bank_row_o[b]   = req_addr_i[winner[b]].fields.row;
      bank_wen_o[b]   = req_wen_i[winner[b]];
      bank_wdata_o[b] = req_wdata_i[winner[b]];
      bank_be_o[b]    = req_be_i[winner[b]];
      bank_ini_o[b]   = winner[b];
      // Only the granted tile sees ready
      if (bank_valid_o[b] && bank_ready_i[b]) begin
        req_ready_o[winner[b]] = 1'b1;
      end
    end
  end

  // Pointer moves just past the winner on every transfer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr <= '0;
    end else begin
      for (int b = 0; b < `MEMPOOL_NUM_BANKS; b++) begin
        if (bank_valid_o[b] && bank_ready_i[b]) begin
          rr_ptr[b] <= winner[b] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tcdm_pkg.sv ====
// TCDM package
// Word address union plus the arbitration and byte-merge helpers
// shared by the crossbars, the banks and the reference memory

`default_nettype none

`include "mempool_settings.svh"

package tcdm_pkg;

  // Word-interleaved: low bits pick the bank, high bits the row
  typedef union packed {
    logic [`MEMPOOL_ADDR_WIDTH-1:0] raw;
    struct packed {
      logic [`MEMPOOL_ROW_WIDTH-1:0]      row;
      logic [`MEMPOOL_BANK_IDX_WIDTH-1:0] bank;
    } fields;
  } tcdm_addr_u;

  // First requester at or after ptr, wrapping around
  // Used for both crossbars since a group has one bank per tile
  function automatic logic [`MEMPOOL_TILE_IDX_WIDTH-1:0] rr_pick(
    input logic [`MEMPOOL_NUM_TILES-1:0]      req,
    input logic [`MEMPOOL_TILE_IDX_WIDTH-1:0] ptr
  );
    logic [`MEMPOOL_TILE_IDX_WIDTH-1:0] idx;
    logic [`MEMPOOL_TILE_IDX_WIDTH-1:0] pick;
    logic                               found;
    pick  = ptr;
    found = 1'b0;
    for (int i = 0; i < `MEMPOOL_NUM_TILES; i++) begin
      idx = ptr + i[`MEMPOOL_TILE_IDX_WIDTH-1:0];
      if (!found && req[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  function automatic logic [`MEMPOOL_DATA_WIDTH-1:0] be_merge(
    input logic [`MEMPOOL_DATA_WIDTH-1:0] old_word,
    input logic [`MEMPOOL_DATA_WIDTH-1:0] new_word,
    input logic [`MEMPOOL_BE_WIDTH-1:0]   be
  );
    logic [`MEMPOOL_DATA_WIDTH-1:0] merged;
    merged = old_word;
    for (int b = 0; b < `MEMPOOL_BE_WIDTH; b++) begin
      if (be[b]) begin
        merged[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// ==== mempool_settings.svh ====
// MemPool group settings
// Tile, bank and word geometry of the local TCDM path

`ifndef MEMPOOL_SETTINGS_SVH
`define MEMPOOL_SETTINGS_SVH

// One bank per tile
`define MEMPOOL_NUM_TILES       4
`define MEMPOOL_NUM_BANKS       4
`define MEMPOOL_TILE_IDX_WIDTH  2
`define MEMPOOL_BANK_IDX_WIDTH  2

// 64 words per bank
`define MEMPOOL_ROW_WIDTH       6
`define MEMPOOL_ADDR_WIDTH      (`MEMPOOL_ROW_WIDTH + `MEMPOOL_BANK_IDX_WIDTH)

`define MEMPOOL_DATA_WIDTH      32
`define MEMPOOL_BE_WIDTH        (`MEMPOOL_DATA_WIDTH / 8)

`endif
